/* src/tetris_settings.svh */
`ifndef TETRIS_SETTINGS_SVH
`define TETRIS_SETTINGS_SVH

`define TETRIS_ROWS    22 // row 0 is the top row
`define TETRIS_COLS    10
`define TETRIS_COLOR_W 3  // code 0 is an empty cell

`endif

/* src/tetris_pkg.sv */
`default_nettype none

`include "tetris_settings.svh"

package tetris_pkg;

    typedef logic [`TETRIS_COLOR_W-1:0] color_t;
    typedef color_t [`TETRIS_COLS-1:0] row_t;
    typedef row_t [`TETRIS_ROWS-1:0] board_t; // [row][col], same shape as the display

    typedef logic [`TETRIS_COLS-1:0] mask_row_t;
    typedef mask_row_t [`TETRIS_ROWS-1:0] mask_t;

    typedef logic [$clog2(`TETRIS_ROWS)-1:0] row_idx_t;
    typedef logic [15:0] line_count_t;

    typedef enum logic [2:0] {
        LINE      = 3'd0,
        SMASHBOY  = 3'd1,
        L         = 3'd2,
        REVERSE_L = 3'd3,
        S         = 3'd4,
        Z         = 3'd5,
        T         = 3'd6
    } piece_kind_t;

    typedef enum logic [1:0] {
        MOVE_LEFT,
        MOVE_RIGHT,
        MOVE_DOWN,
        MOVE_SPAWN
    } move_op_t;

    typedef enum logic [1:0] {
        CMD_LEFT  = 2'd0,
        CMD_RIGHT = 2'd1,
        CMD_DOWN  = 2'd2
    } cmd_t;

    typedef enum logic [2:0] {
        SPAWN,
        IDLE,
        MOVE,
        MERGE,
        CLEAR,
        RESPAWN,
        ACK,
        OVER
    } ctrl_state_t;

endpackage

`default_nettype wire

/* src/blockgen.sv */
`timescale 1ns/1ps
`default_nettype none

module blockgen import tetris_pkg::*; (
    input  piece_kind_t kind,
    output mask_t       spawn_mask,
    output color_t      spawn_color
);

    always_comb begin
        spawn_mask  = '0;
        spawn_color = '0;
        case (kind)
            LINE: begin // vertical bar
                spawn_color      = 3'd3;
                spawn_mask[0][4] = 1'b1;
                spawn_mask[1][4] = 1'b1;
                spawn_mask[2][4] = 1'b1;
                spawn_mask[3][4] = 1'b1;
            end
            SMASHBOY: begin // 2x2 square
                spawn_color      = 3'd6;
                spawn_mask[0][4] = 1'b1;
                spawn_mask[0][5] = 1'b1;
                spawn_mask[1][4] = 1'b1;
                spawn_mask[1][5] = 1'b1;
            end
            L: begin
                spawn_color      = 3'd7;
                spawn_mask[0][4] = 1'b1;
                spawn_mask[1][4] = 1'b1;
                spawn_mask[2][4] = 1'b1;
                spawn_mask[2][5] = 1'b1; // foot to the right
            end
            REVERSE_L: begin
                spawn_color      = 3'd1;
                spawn_mask[0][5] = 1'b1;
                spawn_mask[1][5] = 1'b1;
                spawn_mask[2][5] = 1'b1;
                spawn_mask[2][4] = 1'b1; // foot to the left
            end
            S: begin
                spawn_color      = 3'd2;
                spawn_mask[0][6] = 1'b1;
                spawn_mask[0][5] = 1'b1;
                spawn_mask[1][5] = 1'b1;
                spawn_mask[1][4] = 1'b1;
            end
            Z: begin
                spawn_color      = 3'd4;
                spawn_mask[0][4] = 1'b1;
                spawn_mask[0][5] = 1'b1;
                spawn_mask[1][5] = 1'b1;
                spawn_mask[1][6] = 1'b1;
            end
            T: begin // nub on top
                spawn_color      = 3'd5;
                spawn_mask[0][4] = 1'b1;
                spawn_mask[1][3] = 1'b1;
                spawn_mask[1][4] = 1'b1;
                spawn_mask[1][5] = 1'b1;
            end
            default: begin
                spawn_mask  = '0; // unknown kind spawns nothing
                spawn_color = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/piece_mover.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_settings.svh"

module piece_mover import tetris_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  mask_t  spawn_mask,
    input  color_t spawn_color,
    move_if.mover  mv,
    stack_if.mover st,
    output mask_t  piece_mask,
    output color_t piece_color
);

    mask_t cand; // piece after the requested move
    logic  wall; // candidate would leave the board
    logic  hit;

    always_comb begin
        cand = '0;
        wall = 1'b0;
        case (mv.op)
            MOVE_LEFT: begin
                for (int r = 0; r < `TETRIS_ROWS; r++) begin
                    cand[r] = piece_mask[r] >> 1;
                    wall    = wall | piece_mask[r][0];
                end
            end
            MOVE_RIGHT: begin
                for (int r = 0; r < `TETRIS_ROWS; r++) begin
                    cand[r] = piece_mask[r] << 1;
                    wall    = wall | piece_mask[r][`TETRIS_COLS-1];
                end
            end
            MOVE_DOWN: begin
                cand = piece_mask << `TETRIS_COLS; // one row toward the floor
                wall = |piece_mask[`TETRIS_ROWS-1];
            end
            default: begin
                cand = spawn_mask;
            end
        endcase
    end

    assign hit = wall | (|(cand & st.occupied));

    always_ff @(posedge clk) begin
        if (reset) begin
            piece_mask <= '0;
            mv.done    <= 1'b0;
            mv.blocked <= 1'b0;
        end else begin
            mv.done <= mv.start; // answer one cycle after start
            if (mv.start) begin
                mv.blocked <= hit;
                if (!hit) begin
                    piece_mask <= cand;
                end else if (mv.op == MOVE_SPAWN) begin
                    // no room at the top, show the stack alone
                    piece_mask <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mv.start && mv.op == MOVE_SPAWN && !hit) begin
            piece_color <= spawn_color;
        end
    end

    assign st.merge_mask  = piece_mask; // lock writes the piece as it stands
    assign st.merge_color = piece_color;

endmodule

`default_nettype wire

/* src/stack_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_settings.svh"

module stack_store import tetris_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    stack_if.stack st,
    output board_t cells
);

    logic        scanning;
    row_idx_t    scan_row; // row under test, moves bottom to top
    line_count_t count;
    logic        row_full;

    always_comb begin
        for (int r = 0; r < `TETRIS_ROWS; r++) begin
            for (int c = 0; c < `TETRIS_COLS; c++) begin
                st.occupied[r][c] = |cells[r][c];
            end
        end
    end

    assign row_full = &st.occupied[scan_row];

    always_ff @(posedge clk) begin
        if (reset) begin
            cells         <= '0; // new game starts on an empty well
            scanning      <= 1'b0;
            st.clear_done <= 1'b0;
        end else begin
            st.clear_done <= 1'b0;
            if (st.merge) begin
                for (int r = 0; r < `TETRIS_ROWS; r++) begin
                    for (int c = 0; c < `TETRIS_COLS; c++) begin
                        if (st.merge_mask[r][c]) begin
                            cells[r][c] <= st.merge_color;
                        end
                    end
                end
            end
            if (st.clear_start) begin
                scanning <= 1'b1;
                scan_row <= row_idx_t'(`TETRIS_ROWS - 1);
                count    <= '0;
            end else if (scanning) begin
                if (row_full) begin
                    // drop everything above, stay on this row and test it again
                    for (int r = 0; r < `TETRIS_ROWS; r++) begin
                        if (r == 0) begin
                            cells[r] <= '0;
                        end else if (row_idx_t'(r) <= scan_row) begin
                            cells[r] <= cells[r-1];
                        end
                    end
                    count <= count + 1'b1;
                end else if (scan_row == '0) begin
                    scanning        <= 1'b0;
                    st.clear_done   <= 1'b1;
                    st.cleared_rows <= count;
                end else begin
                    scan_row <= scan_row - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/game_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module game_ctrl import tetris_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_req,
    input  cmd_t        cmd,
    output logic        cmd_ack,
    move_if.ctrl        mv,
    stack_if.ctrl       st,
    output logic        game_over,
    output line_count_t lines_cleared
);

    ctrl_state_t state;
    logic        cmd_busy; // a command is in flight, ack it when done

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= SPAWN;
            cmd_busy       <= 1'b0;
            cmd_ack        <= 1'b0;
            game_over      <= 1'b0;
            lines_cleared  <= '0;
            mv.op          <= MOVE_SPAWN;
            mv.start       <= 1'b0;
            st.merge       <= 1'b0;
            st.clear_start <= 1'b0;
        end else begin
            mv.start       <= 1'b0; // single-cycle pulses
            st.merge       <= 1'b0;
            st.clear_start <= 1'b0;
            case (state)
                SPAWN, RESPAWN: begin
                    mv.op    <= MOVE_SPAWN;
                    mv.start <= 1'b1;
                    state    <= MOVE;
                end
                IDLE: begin
                    if (cmd_req) begin
                        cmd_busy <= 1'b1;
                        case (cmd)
                            CMD_LEFT: begin
                                mv.op    <= MOVE_LEFT;
                                mv.start <= 1'b1;
                                state    <= MOVE;
                            end
                            CMD_RIGHT: begin
                                mv.op    <= MOVE_RIGHT;
                                mv.start <= 1'b1;
                                state    <= MOVE;
                            end
                            CMD_DOWN: begin
                                mv.op    <= MOVE_DOWN;
                                mv.start <= 1'b1;
                                state    <= MOVE;
                            end
                            default: begin
                                cmd_ack <= 1'b1; // unknown code, ack only
                                state   <= ACK;
                            end
                        endcase
                    end
                end
                MOVE: begin
                    if (mv.done) begin
                        if (mv.op == MOVE_SPAWN) begin
                            if (mv.blocked) begin
                                game_over <= 1'b1;
                                state     <= OVER;
                            end else if (cmd_busy) begin
                                cmd_ack <= 1'b1;
                                state   <= ACK;
                            end else begin
                                state <= IDLE; // first piece after reset
                            end
                        end else if (mv.blocked && mv.op == MOVE_DOWN) begin
                            st.merge <= 1'b1; // piece rests, lock it
                            state    <= MERGE;
                        end else begin
                            cmd_ack <= 1'b1; // wall hits are acked as well
                            state   <= ACK;
                        end
                    end
                end
                MERGE: begin
                    st.clear_start <= 1'b1;
                    state          <= CLEAR;
                end
                CLEAR: begin
                    if (st.clear_done) begin
                        lines_cleared <= lines_cleared + st.cleared_rows;
                        state         <= RESPAWN;
                    end
                end
                ACK: begin
                    if (!cmd_req) begin
                        cmd_ack  <= 1'b0;
                        cmd_busy <= 1'b0;
                        state    <= IDLE;
                    end
                end
                OVER: begin
                    // handshake only, the board stays frozen
                    if (cmd_req && !cmd_ack) begin
                        cmd_ack <= 1'b1;
                    end else if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/tetris_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_settings.svh"

interface move_if import tetris_pkg::*; ();
    move_op_t op;
    logic     start;
    logic     done;
    logic     blocked; // valid with done

    modport ctrl  (output op, output start, input done, input blocked);
    modport mover (input op, input start, output done, output blocked);
endinterface

interface stack_if import tetris_pkg::*; ();
    mask_t       occupied;
    logic        merge;
    mask_t       merge_mask;
    color_t      merge_color;
    logic        clear_start;
    logic        clear_done;
    line_count_t cleared_rows; // valid with clear_done

    modport stack (output occupied, input merge, input merge_mask, input merge_color,
                   input clear_start, output clear_done, output cleared_rows);
    modport ctrl  (output merge, output clear_start, input clear_done, input cleared_rows);
    modport mover (input occupied, output merge_mask, output merge_color);
endinterface

module tetris_core import tetris_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_req,
    input  cmd_t        cmd,
    output logic        cmd_ack,
    input  piece_kind_t next_piece,
    output board_t      display_array,
    output logic        game_over,
    output line_count_t lines_cleared
);

    mask_t  spawn_mask;
    color_t spawn_color;
    mask_t  piece_mask;
    color_t piece_color;
    board_t stack_cells;

    move_if  mv_bus ();
    stack_if st_bus ();

    blockgen u_blockgen (
        .kind        (next_piece),
        .spawn_mask  (spawn_mask),
        .spawn_color (spawn_color)
    );

    piece_mover u_mover (
        .clk         (clk),
        .reset       (reset),
        .spawn_mask  (spawn_mask),
        .spawn_color (spawn_color),
        .mv          (mv_bus),
        .st          (st_bus),
        .piece_mask  (piece_mask),
        .piece_color (piece_color)
    );

    stack_store u_stack (
        .clk   (clk),
        .reset (reset),
        .st    (st_bus),
        .cells (stack_cells)
    );

    game_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .cmd_req       (cmd_req),
        .cmd           (cmd),
        .cmd_ack       (cmd_ack),
        .mv            (mv_bus),
        .st            (st_bus),
        .game_over     (game_over),
        .lines_cleared (lines_cleared)
    );

    always_comb begin
        for (int r = 0; r < `TETRIS_ROWS; r++) begin
            for (int c = 0; c < `TETRIS_COLS; c++) begin
                // falling piece drawn over the settled cells
                display_array[r][c] = piece_mask[r][c] ? piece_color : stack_cells[r][c];
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_tetris.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_settings.svh"

module tb_tetris import tetris_pkg::*; ();

    localparam int ACK_TIMEOUT  = 400; // lock plus a full clear scan fits well inside
    localparam int DROP_TIMEOUT = 2;   // ack falls the cycle after cmd_req drops

    logic        clk;
    logic        reset;
    logic        cmd_req;
    cmd_t        cmd;
    logic        cmd_ack;
    piece_kind_t next_piece;
    board_t      display_array;
    logic        game_over;
    line_count_t lines_cleared;

    board_t      m_stack; // reference model of the core
    mask_t       m_piece;
    color_t      m_color;
    logic        m_over;
    line_count_t m_lines;

    logic [31:0] lfsr = 32'h90a0_0c5c;
    string       test_name = "none";
    int          checks_asked = 0;
    int          checks_done = 0;
    int          board_errs = 0;
    int          count_errs = 0;
    int          flag_errs = 0;
    int          timeout_errs = 0;

    tetris_core u_dut (
        .clk           (clk),
        .reset         (reset),
        .cmd_req       (cmd_req),
        .cmd           (cmd),
        .cmd_ack       (cmd_ack),
        .next_piece    (next_piece),
        .display_array (display_array),
        .game_over     (game_over),
        .lines_cleared (lines_cleared)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (100000) @(posedge clk);
        $display("ERROR: run did not finish within the cycle limit");
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic mask_t spawn_mask_of(input piece_kind_t k);
        mask_t m;
        int    rc[8]; // row, col of each of the four cells
        m = '0;
        case (k)
            LINE:      rc = '{0, 4, 1, 4, 2, 4, 3, 4};
            SMASHBOY:  rc = '{0, 4, 0, 5, 1, 4, 1, 5};
            L:         rc = '{0, 4, 1, 4, 2, 4, 2, 5};
            REVERSE_L: rc = '{0, 5, 1, 5, 2, 5, 2, 4};
            S:         rc = '{0, 5, 0, 6, 1, 4, 1, 5};
            Z:         rc = '{0, 4, 0, 5, 1, 5, 1, 6};
            T:         rc = '{0, 4, 1, 3, 1, 4, 1, 5};
            default:   return '0;
        endcase
        for (int i = 0; i < 4; i++) begin
            m[rc[2*i]][rc[2*i+1]] = 1'b1;
        end
        return m;
    endfunction

    function automatic color_t spawn_color_of(input piece_kind_t k);
        case (k)
            LINE:      return 3'd3;
            SMASHBOY:  return 3'd6;
            L:         return 3'd7;
            REVERSE_L: return 3'd1;
            S:         return 3'd2;
            Z:         return 3'd4;
            T:         return 3'd5;
            default:   return 3'd0;
        endcase
    endfunction

    // returns 1 when a cell would leave the board
    function automatic logic shift_piece(input mask_t m, input int dr, input int dc,
                                         output mask_t moved);
        logic wall;
        wall  = 1'b0;
        moved = '0;
        for (int r = 0; r < `TETRIS_ROWS; r++) begin
            for (int c = 0; c < `TETRIS_COLS; c++) begin
                if (m[r][c]) begin
                    if (r + dr < 0 || r + dr >= `TETRIS_ROWS ||
                        c + dc < 0 || c + dc >= `TETRIS_COLS) begin
                        wall = 1'b1;
                    end else begin
                        moved[r+dr][c+dc] = 1'b1;
                    end
                end
            end
        end
        return wall;
    endfunction

    function automatic logic collides(input mask_t m, input board_t b);
        logic hit;
        hit = 1'b0;
        for (int r = 0; r < `TETRIS_ROWS; r++) begin
            for (int c = 0; c < `TETRIS_COLS; c++) begin
                if (m[r][c] && b[r][c] != '0) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // keeps the rows that are not full packed toward the floor
    function automatic int clear_full_rows(input board_t b, output board_t nb);
        int wr;
        int full;
        int removed;
        nb      = '0;
        wr      = `TETRIS_ROWS - 1;
        removed = 0;
        for (int r = `TETRIS_ROWS - 1; r >= 0; r--) begin
            full = 1;
            for (int c = 0; c < `TETRIS_COLS; c++) begin
                if (b[r][c] == '0) begin
                    full = 0;
                end
            end
            if (full == 1) begin
                removed++;
            end else begin
                nb[wr] = b[r];
                wr--;
            end
        end
        return removed;
    endfunction

    function automatic board_t expected_display(input board_t st, input mask_t pm,
                                                input color_t pc);
        board_t d;
        d = st;
        for (int r = 0; r < `TETRIS_ROWS; r++) begin
            for (int c = 0; c < `TETRIS_COLS; c++) begin
                if (pm[r][c]) begin
                    d[r][c] = pc;
                end
            end
        end
        return d;
    endfunction

    task automatic model_spawn(input piece_kind_t k);
        mask_t m;
        m = spawn_mask_of(k);
        if (collides(m, m_stack)) begin
            m_over  = 1'b1; // no room so the board freezes here
            m_piece = '0;
        end else begin
            m_piece = m;
            m_color = spawn_color_of(k);
        end
    endtask

    task automatic model_reset(input piece_kind_t k);
        m_stack = '0;
        m_piece = '0;
        m_color = '0;
        m_over  = 1'b0;
        m_lines = '0;
        model_spawn(k);
    endtask

    task automatic model_cmd(input cmd_t c, input piece_kind_t nxt, output logic locked);
        mask_t  cand;
        board_t nb;
        logic   wall;
        int     dr;
        int     dc;
        int     removed;
        locked = 1'b0;
        if (m_over) begin
            return;
        end
        dr   = (c == CMD_DOWN) ? 1 : 0;
        dc   = (c == CMD_LEFT) ? -1 : ((c == CMD_RIGHT) ? 1 : 0);
        wall = shift_piece(m_piece, dr, dc, cand);
        if (!wall && !collides(cand, m_stack)) begin
            m_piece = cand;
        end else if (c == CMD_DOWN) begin
            locked  = 1'b1;
            m_stack = expected_display(m_stack, m_piece, m_color); // lock in place
            removed = clear_full_rows(m_stack, nb);
            m_stack = nb;
            m_lines = m_lines + line_count_t'(removed);
            model_spawn(nxt);
        end
    endtask

    task automatic check_board(input string name, input board_t exp, input board_t act);
        if (act !== exp) begin
            board_errs++;
            $display("CHECK FAILED %s display: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input line_count_t exp,
                               input line_count_t act);
        if (act !== exp) begin
            count_errs++;
            $display("CHECK FAILED %s lines: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("CHECK FAILED %s game_over: expected %b actual %b", name, exp, act);
        end
    endtask

    always @(negedge clk) begin
        if (checks_done != checks_asked) begin
            check_board(test_name, expected_display(m_stack, m_piece, m_color), display_array);
            check_count(test_name, m_lines, lines_cleared);
            check_flag(test_name, m_over, game_over);
            checks_done = checks_asked;
        end
    end

    task automatic request_check();
        int n;
        checks_asked++;
        n = 0;
        while (checks_done != checks_asked && n < 4) begin
            @(posedge clk);
            n++;
        end
        if (checks_done != checks_asked) begin
            timeout_errs++;
            $display("ERROR: %s: compare process did not run", test_name);
        end
    endtask

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic apply_reset(input piece_kind_t k);
        @(posedge clk);
        reset      <= 1'b1;
        cmd_req    <= 1'b0;
        next_piece <= k;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk); // spawn is shown within 3 cycles
        model_reset(k);
        request_check();
    endtask

    task automatic handshake(input cmd_t c, input piece_kind_t nxt);
        int n;
        @(posedge clk);
        cmd        <= c;
        next_piece <= nxt;
        cmd_req    <= 1'b1;
        n = 0;
        while (cmd_ack !== 1'b1 && n < ACK_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (cmd_ack !== 1'b1) begin
            timeout_errs++;
            $display("ERROR: %s: cmd_ack never rose", test_name);
        end
        cmd_req <= 1'b0;
        n = 0;
        while (cmd_ack !== 1'b0 && n < DROP_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (cmd_ack !== 1'b0) begin
            timeout_errs++;
            $display("ERROR: %s: cmd_ack did not fall the cycle after cmd_req fell",
                     test_name);
        end
    endtask

    task automatic do_cmd(input cmd_t c, input piece_kind_t nxt, output logic locked);
        handshake(c, nxt);
        model_cmd(c, nxt, locked);
        request_check();
    endtask

    task automatic repeat_cmd(input cmd_t c, input int times, input piece_kind_t nxt);
        logic locked;
        for (int i = 0; i < times; i++) begin
            do_cmd(c, nxt, locked);
        end
    endtask

    task automatic drop_until_lock(input piece_kind_t nxt);
        logic locked;
        int   n;
        locked = 1'b0;
        n      = 0;
        while (!locked && n < 30) begin
            do_cmd(CMD_DOWN, nxt, locked);
            n++;
        end
    endtask

    initial begin
        cmd_t c;
        logic locked;
        int   v;
        reset      <= 1'b1;
        cmd_req    <= 1'b0;
        cmd        <= CMD_LEFT;
        next_piece <= LINE;

        test_name = "spawn table";
        for (int k = 0; k < 7; k++) begin
            apply_reset(piece_kind_t'(k));
        end

        test_name = "left right walls";
        apply_reset(T);
        repeat_cmd(CMD_LEFT, 4, T); // last one hits the left wall
        repeat_cmd(CMD_RIGHT, 8, T);

        test_name = "drop and lock";
        apply_reset(L);
        drop_until_lock(Z);
        drop_until_lock(S); // lands on the L
        drop_until_lock(T);

        test_name = "random sequence";
        random_bits(3, v);
        apply_reset(piece_kind_t'(v % 7));
        for (int i = 0; i < 300; i++) begin
            random_bits(2, v);
            c = (v == 0) ? CMD_LEFT : ((v == 1) ? CMD_RIGHT : CMD_DOWN);
            random_bits(3, v);
            do_cmd(c, piece_kind_t'(v % 7), locked);
        end

        test_name = "four line clear";
        apply_reset(LINE);
        for (int col = 0; col < 10; col++) begin
            if (col < 4) begin
                repeat_cmd(CMD_LEFT, 4 - col, LINE);
            end else begin
                repeat_cmd(CMD_RIGHT, col - 4, LINE);
            end
            drop_until_lock(LINE);
        end

        test_name = "stack to top";
        apply_reset(SMASHBOY);
        for (int i = 0; i < 12 && !m_over; i++) begin
            drop_until_lock(SMASHBOY);
        end
        do_cmd(CMD_LEFT, SMASHBOY, locked); // frozen board acks only
        do_cmd(CMD_RIGHT, SMASHBOY, locked);
        do_cmd(CMD_DOWN, SMASHBOY, locked);

        $display("errors: board %0d lines %0d flag %0d timeout %0d",
                 board_errs, count_errs, flag_errs, timeout_errs);
        if (board_errs + count_errs + flag_errs + timeout_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/tetris_pkg.sv
src/blockgen.sv
src/piece_mover.sv
src/stack_store.sv
src/game_ctrl.sv
src/tetris_core.sv
sim/tb_tetris.sv

/* Makefile */
# Verilator flow for the falling-block core

VERILATOR ?= verilator
TOP       ?= tb_tetris
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^=== PASS ===$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
